/* fu_pkg.sv */
package fu_pkg;

  // datapath and tag widths
  localparam int xlen  = 64;
  localparam int tag_w = 6;

  // multiplier pipeline, one slice of operand b per stage
  localparam int mult_stages  = 4;
  localparam int mult_slice_w = xlen / mult_stages;

  // physical register tag carried with each instruction
  typedef logic [tag_w-1:0] tag_t;

  // integer alu opcodes
  typedef enum logic [3:0] {
    alu_addq   = 4'd0,
    alu_subq   = 4'd1,
    alu_and    = 4'd2,
    alu_bic    = 4'd3,
    alu_bis    = 4'd4,
    alu_ornot  = 4'd5,
    alu_xor    = 4'd6,
    alu_eqv    = 4'd7,
    alu_srl    = 4'd8,
    alu_sll    = 4'd9,
    alu_sra    = 4'd10,
    alu_cmpult = 4'd11,
    alu_cmpeq  = 4'd12,
    alu_cmpule = 4'd13,
    alu_cmplt  = 4'd14,
    alu_cmple  = 4'd15
  } alu_func_e;

  // source of alu operand b
  typedef enum logic {
    opb_is_regb = 1'b0,
    opb_is_imm  = 1'b1  // 8-bit literal, zero extended
  } opb_sel_e;

  // branch conditions, bit 2 negates the base test in bits 1:0
  typedef enum logic [2:0] {
    br_lbc = 3'b000,
    br_eq  = 3'b001,
    br_lt  = 3'b010,
    br_le  = 3'b011,
    br_lbs = 3'b100,
    br_ne  = 3'b101,
    br_ge  = 3'b110,
    br_gt  = 3'b111
  } br_cond_e;

endpackage

/* alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    issue,
  input  fu_pkg::alu_func_e       func,
  input  fu_pkg::tag_t            tag,
  input  logic [fu_pkg::xlen-1:0] opa,
  input  logic [fu_pkg::xlen-1:0] opb,
  input  logic [7:0]              lit,
  input  fu_pkg::opb_sel_e        opb_sel,
  input  logic                    grant,
  output logic                    free,
  output logic                    done,
  output fu_pkg::tag_t            done_tag,
  output logic [fu_pkg::xlen-1:0] done_value
);

  logic [fu_pkg::xlen-1:0] opb_val;
  logic [fu_pkg::xlen-1:0] result;

  // signed less-than built on an unsigned compare
  function automatic logic signed_lt(input logic [fu_pkg::xlen-1:0] a,
                                     input logic [fu_pkg::xlen-1:0] b);
    if (a[fu_pkg::xlen-1] == b[fu_pkg::xlen-1]) begin
      signed_lt = (a < b);              // same sign
    end else begin
      signed_lt = a[fu_pkg::xlen-1];    // negative a is the smaller one
    end
  endfunction

  assign opb_val = (opb_sel == fu_pkg::opb_is_imm) ? {{(fu_pkg::xlen-8){1'b0}}, lit} : opb;

  always_comb begin
    result = '0;
    case (func)
      fu_pkg::alu_addq:   result = opa + opb_val;
      fu_pkg::alu_subq:   result = opa - opb_val;
      fu_pkg::alu_and:    result = opa & opb_val;
      fu_pkg::alu_bic:    result = opa & ~opb_val;
      fu_pkg::alu_bis:    result = opa | opb_val;
      fu_pkg::alu_ornot:  result = opa | ~opb_val;
      fu_pkg::alu_xor:    result = opa ^ opb_val;
      fu_pkg::alu_eqv:    result = opa ^ ~opb_val;
      fu_pkg::alu_srl:    result = opa >> opb_val[5:0];
      fu_pkg::alu_sll:    result = opa << opb_val[5:0];
      fu_pkg::alu_sra:    result = $signed(opa) >>> opb_val[5:0];  // fills with sign
      fu_pkg::alu_cmpult: result = {63'd0, (opa < opb_val)};
      fu_pkg::alu_cmpeq:  result = {63'd0, (opa == opb_val)};
      fu_pkg::alu_cmpule: result = {63'd0, (opa <= opb_val)};
      fu_pkg::alu_cmplt:  result = {63'd0, signed_lt(opa, opb_val)};
      fu_pkg::alu_cmple:  result = {63'd0, (signed_lt(opa, opb_val) || (opa == opb_val))};
      default:            result = '0;
    endcase
  end

  // empty, or the held result leaves this cycle
  assign free = !done || grant;

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (issue) begin
      done <= 1'b1;          // new result replaces the granted one
    end else if (grant) begin
      done <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      done_tag   <= tag;
      done_value <= result;
    end
  end

  // the scheduler must not issue into a unit still holding an ungranted result
  issue_when_free: assert property (@(posedge clock) disable iff (reset) issue |-> free)
    else $error("alu issued while busy");

endmodule

/* brcond.sv */
`timescale 1ns/1ps

module brcond (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    issue,
  input  fu_pkg::br_cond_e        cond,
  input  fu_pkg::tag_t            tag,
  input  logic [fu_pkg::xlen-1:0] opa,
  input  logic [fu_pkg::xlen-1:0] npc,
  input  logic [fu_pkg::xlen-1:0] disp,
  input  logic                    grant,
  output logic                    free,
  output logic                    done,
  output fu_pkg::tag_t            done_tag,
  output logic [fu_pkg::xlen-1:0] done_value,
  output logic                    done_taken
);

  logic                    base_test;
  logic                    taken;
  logic [fu_pkg::xlen-1:0] target;

  always_comb begin
    case (cond[1:0])
      2'b00:   base_test = !opa[0];                                  // lbc
      2'b01:   base_test = (opa == '0);                              // eq
      2'b10:   base_test = opa[fu_pkg::xlen-1];                      // lt
      default: base_test = opa[fu_pkg::xlen-1] || (opa == '0);       // le
    endcase
  end

  assign taken  = base_test ^ cond[2];             // upper half of the codes negates
  assign target = npc + {disp[fu_pkg::xlen-3:0], 2'b00};  // displacement in words

  assign free = !done || grant;

  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else if (issue) begin
      done <= 1'b1;
    end else if (grant) begin
      done <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      done_tag   <= tag;
      done_value <= taken ? target : npc;   // fall through to npc
      done_taken <= taken;
    end
  end

  issue_when_free: assert property (@(posedge clock) disable iff (reset) issue |-> free)
    else $error("branch unit issued while busy");

endmodule

/* mult.sv */
`timescale 1ns/1ps

module mult (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    issue,
  input  fu_pkg::tag_t            tag,
  input  logic [fu_pkg::xlen-1:0] opa,
  input  logic [fu_pkg::xlen-1:0] opb,
  input  logic                    grant,
  output logic                    free,
  output logic                    done,
  output fu_pkg::tag_t            done_tag,
  output logic [fu_pkg::xlen-1:0] done_value
);

  // per stage state, the last stage needs no operands any more
  logic [fu_pkg::mult_stages-1:0] stage_valid;
  fu_pkg::tag_t                   stage_tag [fu_pkg::mult_stages];
  logic [fu_pkg::xlen-1:0]        stage_sum [fu_pkg::mult_stages];
  logic [fu_pkg::xlen-1:0]        stage_a   [fu_pkg::mult_stages-1];
  logic [fu_pkg::xlen-1:0]        stage_b   [fu_pkg::mult_stages-1];

  // partial product added on the way into each stage
  logic [fu_pkg::xlen-1:0]        partial   [fu_pkg::mult_stages];
  logic                           advance;

  // whole pipe moves unless the finished product is still waiting
  assign advance = !stage_valid[fu_pkg::mult_stages-1] || grant;
  assign free    = advance;

  assign partial[0] = opa * {{(fu_pkg::xlen-fu_pkg::mult_slice_w){1'b0}},
                             opb[fu_pkg::mult_slice_w-1:0]};

  for (genvar i = 1; i < fu_pkg::mult_stages; i++) begin : g_slice
    logic [fu_pkg::mult_slice_w-1:0] b_slice;

    assign b_slice    = stage_b[i-1][i*fu_pkg::mult_slice_w +: fu_pkg::mult_slice_w];
    assign partial[i] = (stage_a[i-1] * {{(fu_pkg::xlen-fu_pkg::mult_slice_w){1'b0}}, b_slice})
                        << (i * fu_pkg::mult_slice_w);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid <= {stage_valid[fu_pkg::mult_stages-2:0], issue};
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      stage_tag[0] <= tag;
      stage_sum[0] <= partial[0];
      stage_a[0]   <= opa;
      stage_b[0]   <= opb;
      for (int i = 1; i < fu_pkg::mult_stages; i++) begin
        stage_tag[i] <= stage_tag[i-1];
        stage_sum[i] <= stage_sum[i-1] + partial[i];  // running sum, low 64 bits
      end
      for (int i = 1; i < fu_pkg::mult_stages - 1; i++) begin
        stage_a[i] <= stage_a[i-1];
        stage_b[i] <= stage_b[i-1];
      end
    end
  end

  assign done       = stage_valid[fu_pkg::mult_stages-1];
  assign done_tag   = stage_tag[fu_pkg::mult_stages-1];
  assign done_value = stage_sum[fu_pkg::mult_stages-1];

  // a product waiting on the arbiter stays put until it is taken
  hold_until_grant: assert property (
    @(posedge clock) disable iff (reset)
    (done && !grant) |=> (done && $stable(done_tag) && $stable(done_value))
  ) else $error("multiplier result changed before grant");

endmodule

/* cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic                    mult_done,
  input  logic                    alu_done,
  input  logic                    br_done,
  input  fu_pkg::tag_t            mult_tag,
  input  fu_pkg::tag_t            alu_tag,
  input  fu_pkg::tag_t            br_tag,
  input  logic [fu_pkg::xlen-1:0] mult_value,
  input  logic [fu_pkg::xlen-1:0] alu_value,
  input  logic [fu_pkg::xlen-1:0] br_value,
  input  logic                    br_taken,
  output logic                    mult_grant,
  output logic                    alu_grant,
  output logic                    br_grant,
  output logic                    cdb_valid,
  output fu_pkg::tag_t            cdb_tag,
  output logic [fu_pkg::xlen-1:0] cdb_value,
  output logic                    cdb_br_taken
);

  // multiplier first since a stall there backs up several products
  assign mult_grant = mult_done;
  assign alu_grant  = alu_done && !mult_done;
  assign br_grant   = br_done && !mult_done && !alu_done;

  assign cdb_valid  = mult_done || alu_done || br_done;

  always_comb begin
    cdb_tag      = '0;
    cdb_value    = '0;
    cdb_br_taken = 1'b0;   // only branches set it
    if (mult_grant) begin
      cdb_tag   = mult_tag;
      cdb_value = mult_value;
    end else if (alu_grant) begin
      cdb_tag   = alu_tag;
      cdb_value = alu_value;
    end else if (br_grant) begin
      cdb_tag      = br_tag;
      cdb_value    = br_value;
      cdb_br_taken = br_taken;
    end
  end

  // one broadcast per cycle
  always_comb begin
    assert ($onehot0({mult_grant, alu_grant, br_grant}))
      else $error("more than one cdb grant");
  end

endmodule

/* fu_cluster.sv */
`timescale 1ns/1ps

module fu_cluster (
  input  logic                    clock,
  input  logic                    reset,
  // alu issue
  input  logic                    alu_issue,
  input  fu_pkg::alu_func_e       alu_func,
  input  fu_pkg::tag_t            alu_tag,
  input  logic [fu_pkg::xlen-1:0] alu_opa,
  input  logic [fu_pkg::xlen-1:0] alu_opb,
  input  logic [7:0]              alu_lit,
  input  fu_pkg::opb_sel_e        alu_opb_sel,
  // multiplier issue
  input  logic                    mult_issue,
  input  fu_pkg::tag_t            mult_tag,
  input  logic [fu_pkg::xlen-1:0] mult_opa,
  input  logic [fu_pkg::xlen-1:0] mult_opb,
  // branch issue
  input  logic                    br_issue,
  input  fu_pkg::br_cond_e        br_cond,
  input  fu_pkg::tag_t            br_tag,
  input  logic [fu_pkg::xlen-1:0] br_opa,
  input  logic [fu_pkg::xlen-1:0] br_npc,
  input  logic [fu_pkg::xlen-1:0] br_disp,
  output logic                    alu_free,
  output logic                    mult_free,
  output logic                    br_free,
  output logic                    cdb_valid,
  output fu_pkg::tag_t            cdb_tag,
  output logic [fu_pkg::xlen-1:0] cdb_value,
  output logic                    cdb_br_taken
);

  logic                    alu_done, mult_done, br_done;
  logic                    alu_grant, mult_grant, br_grant;
  fu_pkg::tag_t            alu_done_tag, mult_done_tag, br_done_tag;
  logic [fu_pkg::xlen-1:0] alu_done_value, mult_done_value, br_done_value;
  logic                    br_done_taken;

  alu alu_i (
    .clock(clock), .reset(reset), .issue(alu_issue), .func(alu_func), .tag(alu_tag),
    .opa(alu_opa), .opb(alu_opb), .lit(alu_lit), .opb_sel(alu_opb_sel), .grant(alu_grant),
    .free(alu_free), .done(alu_done), .done_tag(alu_done_tag), .done_value(alu_done_value)
  );

  mult mult_i (
    .clock(clock), .reset(reset), .issue(mult_issue), .tag(mult_tag),
    .opa(mult_opa), .opb(mult_opb), .grant(mult_grant),
    .free(mult_free), .done(mult_done), .done_tag(mult_done_tag),
    .done_value(mult_done_value)
  );

  brcond brcond_i (
    .clock(clock), .reset(reset), .issue(br_issue), .cond(br_cond), .tag(br_tag),
    .opa(br_opa), .npc(br_npc), .disp(br_disp), .grant(br_grant),
    .free(br_free), .done(br_done), .done_tag(br_done_tag), .done_value(br_done_value),
    .done_taken(br_done_taken)
  );

  cdb_arbiter cdb_arbiter_i (
    .mult_done(mult_done), .alu_done(alu_done), .br_done(br_done),
    .mult_tag(mult_done_tag), .alu_tag(alu_done_tag), .br_tag(br_done_tag),
    .mult_value(mult_done_value), .alu_value(alu_done_value), .br_value(br_done_value),
    .br_taken(br_done_taken),
    .mult_grant(mult_grant), .alu_grant(alu_grant), .br_grant(br_grant),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .cdb_br_taken(cdb_br_taken)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;   // 100 ns period
  end

  // held over 8 rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset <= 1'b0;
  end

endmodule

/* fu_tb_model.svh */
// expected results, taken from the instruction set rules

function automatic logic [63:0] ref_alu(input fu_pkg::alu_func_e func,
                                        input logic [63:0] a, input logic [63:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  sa = a;
  sb = b;
  case (func)
    fu_pkg::alu_addq:   return a + b;
    fu_pkg::alu_subq:   return a - b;
    fu_pkg::alu_and:    return a & b;
    fu_pkg::alu_bic:    return a & ~b;
    fu_pkg::alu_bis:    return a | b;
    fu_pkg::alu_ornot:  return a | ~b;
    fu_pkg::alu_xor:    return a ^ b;
    fu_pkg::alu_eqv:    return ~(a ^ b);
    fu_pkg::alu_srl:    return a >> b[5:0];
    fu_pkg::alu_sll:    return a << b[5:0];
    fu_pkg::alu_sra:    return sa >>> b[5:0];
    fu_pkg::alu_cmpult: return {63'd0, a < b};
    fu_pkg::alu_cmpeq:  return {63'd0, a == b};
    fu_pkg::alu_cmpule: return {63'd0, a <= b};
    fu_pkg::alu_cmplt:  return {63'd0, sa < sb};
    fu_pkg::alu_cmple:  return {63'd0, sa <= sb};
    default:            return 64'd0;
  endcase
endfunction

// low half of the full product
function automatic logic [63:0] ref_mult(input logic [63:0] a, input logic [63:0] b);
  return a * b;
endfunction

function automatic logic ref_br_taken(input fu_pkg::br_cond_e cond, input logic [63:0] a);
  logic signed [63:0] sa;
  sa = a;
  case (cond)
    fu_pkg::br_lbc: return !a[0];
    fu_pkg::br_lbs: return a[0];
    fu_pkg::br_eq:  return a == 64'd0;
    fu_pkg::br_ne:  return a != 64'd0;
    fu_pkg::br_lt:  return sa < 64'sd0;
    fu_pkg::br_ge:  return sa >= 64'sd0;
    fu_pkg::br_le:  return sa <= 64'sd0;
    fu_pkg::br_gt:  return sa > 64'sd0;
    default:        return 1'b0;
  endcase
endfunction

function automatic logic [63:0] ref_br_value(input logic taken, input logic [63:0] npc,
                                             input logic [63:0] disp);
  return taken ? npc + disp * 64'd4 : npc;   // disp counts instructions
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
  checks++;
  if (got !== expected) begin
    errors++;
    $display("FAIL at %0t: %s is %h, expected %h", $time, name, got, expected);
  end
endtask

/* fu_cluster_tb.sv */
`timescale 1ns/1ps

module fu_cluster_tb;

  logic              clock;
  logic              reset;
  logic              alu_issue, mult_issue, br_issue;
  fu_pkg::alu_func_e alu_func;
  fu_pkg::opb_sel_e  alu_opb_sel;
  fu_pkg::br_cond_e  br_cond;
  fu_pkg::tag_t      alu_tag, mult_tag, br_tag;
  logic [63:0]       alu_opa, alu_opb, mult_opa, mult_opb, br_opa, br_npc, br_disp;
  logic [7:0]        alu_lit;
  logic              alu_free, mult_free, br_free;
  logic              cdb_valid, cdb_br_taken;
  fu_pkg::tag_t      cdb_tag;
  logic [63:0]       cdb_value;

  // scoreboard indexed by tag
  logic [63:0]       exp_value [64];
  logic              exp_taken [64];
  logic              pending   [64];
  logic              is_mult   [64];
  logic              is_br     [64];
  logic              has_pair  [64];   // branch issued together with an alu op
  fu_pkg::tag_t      pair_alu  [64];
  fu_pkg::tag_t      mult_order [$];
  fu_pkg::tag_t      next_tag;
  integer            seed;
  int                checks, errors, issued, returned;
  int                last_errors, last_issued;
  logic              timed_out;

  `include "fu_tb_model.svh"

  tb_clock_gen clock_gen_i (.clock(clock), .reset(reset));

  fu_cluster dut_i (.*);

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic next_cycle();
    @(negedge clock);
    alu_issue  = 1'b0;   // strobes last one cycle
    mult_issue = 1'b0;
    br_issue   = 1'b0;
  endtask

  task automatic wait_until_free(input logic need_alu, input logic need_mult,
                                 input logic need_br);
    int waited;
    waited = 0;
    while (!timed_out && ((need_alu && !alu_free) || (need_mult && !mult_free) ||
                          (need_br && !br_free))) begin
      next_cycle();
      waited++;
      if (waited > 50) begin
        timed_out = 1'b1;
        $display("ERROR at %0t: a unit stayed busy for 50 cycles", $time);
      end
    end
  endtask

  task automatic record_expected(output fu_pkg::tag_t t, input logic [63:0] value,
                                 input logic taken, input logic mult, input logic br);
    t = next_tag;
    next_tag = next_tag + 6'd1;   // wraps at 64 which is far more than ever in flight
    exp_value[t] = value;
    exp_taken[t] = taken;
    is_mult[t]   = mult;
    is_br[t]     = br;
    has_pair[t]  = 1'b0;
    pending[t]   = 1'b1;
    issued++;
    if (mult) mult_order.push_back(t);
  endtask

  task automatic issue_alu(input fu_pkg::alu_func_e func, input logic [63:0] a,
                           input logic [63:0] b, input fu_pkg::opb_sel_e sel,
                           output fu_pkg::tag_t t);
    logic [63:0] b_used;
    b_used = (sel == fu_pkg::opb_is_imm) ? {56'd0, b[7:0]} : b;
    record_expected(t, ref_alu(func, a, b_used), 1'b0, 1'b0, 1'b0);
    alu_issue   = 1'b1;
    alu_func    = func;
    alu_tag     = t;
    alu_opa     = a;
    alu_opb     = b;
    alu_lit     = b[7:0];
    alu_opb_sel = sel;
  endtask

  task automatic issue_mult(input logic [63:0] a, input logic [63:0] b,
                            output fu_pkg::tag_t t);
    record_expected(t, ref_mult(a, b), 1'b0, 1'b1, 1'b0);
    mult_issue = 1'b1;
    mult_tag   = t;
    mult_opa   = a;
    mult_opb   = b;
  endtask

  task automatic issue_br(input fu_pkg::br_cond_e cond, input logic [63:0] a,
                          input logic [63:0] npc, input logic [63:0] disp,
                          output fu_pkg::tag_t t);
    logic taken;
    taken = ref_br_taken(cond, a);
    record_expected(t, ref_br_value(taken, npc, disp), taken, 1'b0, 1'b1);
    br_issue = 1'b1;
    br_cond  = cond;
    br_tag   = t;
    br_opa   = a;
    br_npc   = npc;
    br_disp  = disp;
  endtask

  task automatic drain_results(input string name);
    int waited;
    int left;
    waited = 0;
    left = 1;
    while (left != 0 && !timed_out) begin
      next_cycle();
      left = 0;
      for (int i = 0; i < 64; i++) left += int'(pending[i]);
      waited++;
      if (waited > 300) begin
        timed_out = 1'b1;
        $display("ERROR: %s still waits for %0d results after 300 cycles", name, left);
      end
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d issued, %0d errors%s", name, issued - last_issued,
             errors - last_errors, timed_out ? ", timed out" : "");
    last_issued = issued;
    last_errors = errors;
  endtask

  // every broadcast must match one outstanding tag
  task automatic cdb_monitor();
    fu_pkg::tag_t t;
    forever begin
      @(negedge clock);
      if (!reset && cdb_valid) begin
        t = cdb_tag;
        if (!pending[t]) begin
          errors++;
          $display("ERROR at %0t: tag %0d broadcast with nothing outstanding", $time, t);
        end else begin
          check_value("cdb_value", cdb_value, exp_value[t]);
          check_value("cdb_br_taken", 64'(cdb_br_taken), 64'(exp_taken[t]));
          if (is_mult[t]) begin
            if (mult_order.size() == 0 || mult_order[0] != t) begin
              errors++;
              $display("ERROR at %0t: multiplier tag %0d out of issue order", $time, t);
            end
            if (mult_order.size() != 0) mult_order.delete(0);
          end
          if (is_br[t] && has_pair[t] && pending[pair_alu[t]]) begin
            errors++;
            $display("ERROR at %0t: branch tag %0d broadcast before alu tag %0d", $time, t,
                     pair_alu[t]);
          end
          pending[t] = 1'b0;
          returned++;
        end
      end
    end
  endtask

  task automatic check_idle();
    check_value("cdb_valid", 64'(cdb_valid), 64'd0);
    check_value("alu_free", 64'(alu_free), 64'd1);
    check_value("mult_free", 64'(mult_free), 64'd1);
    check_value("br_free", 64'(br_free), 64'd1);
  endtask

  task automatic check_reset();
    int waited;
    waited = 0;
    next_cycle();
    while (reset && !timed_out) begin
      check_idle();
      next_cycle();
      waited++;
      if (waited > 20) begin
        timed_out = 1'b1;
        $display("ERROR: reset never went low");
      end
    end
    repeat (3) begin
      check_idle();
      next_cycle();
    end
  endtask

  task automatic run_alu_ops();
    fu_pkg::tag_t     t;
    logic [63:0]      a;
    logic [63:0]      b;
    fu_pkg::opb_sel_e sel;
    for (int f = 0; f < 16; f++) begin
      for (int s = 0; s < 2; s++) begin
        for (int k = 0; k < 6; k++) begin
          sel = fu_pkg::opb_sel_e'(1'(s));
          a = rand64();
          b = rand64();
          case (k)
            1: begin
              a = 64'h8000_0000_0000_0005;   // negative vs positive
              b = 64'd5;
            end
            2: begin
              a = 64'd7;
              b = 64'hffff_ffff_ffff_fff0;
            end
            3: a = (s == 1) ? {56'd0, b[7:0]} : b;   // equal operands
            4: begin
              a[63] = 1'b1;
              b = 64'd63;
            end
            5: b = 64'd0;
            default: ;
          endcase
          next_cycle();
          wait_until_free(1'b1, 1'b0, 1'b0);
          if (timed_out) return;
          issue_alu(fu_pkg::alu_func_e'(4'(f)), a, b, sel, t);
        end
      end
    end
    drain_results("alu ops");
  endtask

  task automatic run_mult();
    fu_pkg::tag_t t;
    logic [63:0]  a;
    logic [63:0]  b;
    for (int n = 0; n < 40; n++) begin
      a = (n == 0) ? '1 : rand64();
      b = (n == 0) ? '1 : rand64();
      if (n == 1) a = 64'd0;
      next_cycle();
      wait_until_free(1'b0, 1'b1, 1'b0);
      if (timed_out) return;
      issue_mult(a, b, t);
    end
    drain_results("multiplier");
  endtask

  task automatic run_branches();
    fu_pkg::tag_t t;
    logic [63:0]  a;
    logic [63:0]  r;
    for (int c = 0; c < 8; c++) begin
      for (int k = 0; k < 6; k++) begin
        case (k)
          0: a = 64'd0;
          1: a = '1;                        // negative odd
          2: a = 64'hffff_ffff_ffff_fffe;   // negative even
          3: a = 64'd6;
          4: a = 64'd9;
          default: a = rand64();
        endcase
        r = rand64();
        next_cycle();
        wait_until_free(1'b0, 1'b0, 1'b1);
        if (timed_out) return;
        issue_br(fu_pkg::br_cond_e'(3'(c)), a, {r[63:2], 2'b00}, {{48{r[17]}}, r[17:2]}, t);
      end
    end
    drain_results("branches");
  endtask

  task automatic run_contention();
    fu_pkg::tag_t alu_t;
    fu_pkg::tag_t mult_t;
    fu_pkg::tag_t br_t;
    logic [63:0]  r;
    for (int n = 0; n < 30; n++) begin
      next_cycle();
      wait_until_free(1'b1, 1'b1, 1'b1);
      if (timed_out) return;
      r = rand64();
      issue_alu(fu_pkg::alu_func_e'(r[3:0]), rand64(), rand64(),
                fu_pkg::opb_sel_e'(r[4]), alu_t);
      issue_mult(rand64(), rand64(), mult_t);
      issue_br(fu_pkg::br_cond_e'(r[7:5]), rand64(), {r[63:2], 2'b00}, 64'd16, br_t);
      has_pair[br_t] = 1'b1;
      pair_alu[br_t] = alu_t;
    end
    drain_results("contention");
  endtask

  initial begin
    seed = 32'h7de7;
    {alu_issue, mult_issue, br_issue} = 3'b000;
    alu_func    = fu_pkg::alu_addq;
    alu_opb_sel = fu_pkg::opb_is_regb;
    br_cond     = fu_pkg::br_eq;
    {alu_tag, mult_tag, br_tag, next_tag} = '0;
    {alu_opa, alu_opb, mult_opa, mult_opb, br_opa, br_npc, br_disp} = '0;
    alu_lit = 8'd0;
    {checks, errors, issued, returned, last_errors, last_issued} = '0;
    timed_out = 1'b0;
    for (int i = 0; i < 64; i++) begin
      pending[i]  = 1'b0;
      has_pair[i] = 1'b0;
    end
    fork
      cdb_monitor();
    join_none
    check_reset();
    report_test("reset");
    if (!timed_out) begin
      run_alu_ops();
      report_test("alu ops");
    end
    if (!timed_out) begin
      run_mult();
      report_test("multiplier");
    end
    if (!timed_out) begin
      run_branches();
      report_test("branches");
    end
    if (!timed_out) begin
      run_contention();
      report_test("contention");
    end
    $display("summary: %0d checks, %0d errors, %0d issued, %0d returned", checks, errors,
             issued, returned);
    if (errors == 0 && !timed_out && returned == issued) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+.
fu_pkg.sv
alu.sv
brcond.sv
mult.sv
cdb_arbiter.sv
fu_cluster.sv
tb_clock_gen.sv
fu_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with verilator, the verdict comes from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f src.f --top-module fu_cluster_tb -o fu_sim \
  > build.log 2>&1 \
  && ./obj_dir/fu_sim > sim.log 2>&1 \
  || { cat build.log; echo "Test failed" >> sim.log; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
